// ==== src/uartPkg.sv ====
////////////////////////////////////////////////////////////
// serial port shared definitions
// frame widths, tick counts and fifo depth defaults
////////////////////////////////////////////////////////////
`default_nettype none

package uartPkg;

	////////////////////////////////////////////////////////////
	// frame format

	parameter int dataBitsDef = 8;		// data bits per frame
	parameter int sbTickDef = 16;		// ticks in stop period, 16 = one stop bit

	// ticks per bit, fixed by the 16x oversampling scheme
	parameter int overSample = 16;

	////////////////////////////////////////////////////////////
	// fifo and baud rate

	parameter int fifoAddrLenDef = 4;	// 2^4 = 16 entries
	parameter int clkPerTickDef = 4;	// short divider for simulation

	////////////////////////////////////////////////////////////
	// payload

	// one data byte, same width in both fifos
	typedef logic [dataBitsDef-1:0] byte_t;

endpackage

`default_nettype wire

// ==== src/byteFifoIf.sv ====
////////////////////////////////////////////////////////////
// byte fifo bundle
// write side, read side and level flags of one fifo
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface byteFifoIf;

	logic wr;						// write strobe
	uartPkg::byte_t wrData;		// byte being written
	logic rd;						// read strobe, pops head
	uartPkg::byte_t rdData;		// head byte, valid while !empty
	logic empty;
	logic full;

	// writer side, sees only full
	modport producer (
		output wr, wrData,
		input full
	);

	// reader side
	modport consumer (
		output rd,
		input rdData, empty
	);

	// the fifo itself
	modport storage (
		input wr, wrData, rd,
		output rdData, empty, full
	);

endinterface

`default_nettype wire

// ==== src/baudTickGen.sv ====
////////////////////////////////////////////////////////////
// baud tick generator
// one-cycle oversampling tick every clkPerTick clocks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module baudTickGen #(
	parameter int clkPerTick = uartPkg::clkPerTickDef
) (
	input wire logic clk,
	input wire logic reset,
	output logic sTick
);

	// wide enough to hold clkPerTick-1, also for clkPerTick = 1
	localparam int cntLen = $clog2(clkPerTick + 1);

	logic [cntLen-1:0] cntReg;	// modulo counter
	logic wrap;

	assign wrap = (cntReg == cntLen'(clkPerTick - 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cntReg <= '0;
			sTick <= 1'b0;
		end
		else
		begin
			if (wrap)
				cntReg <= '0;		// restart period
			else
				cntReg <= cntReg + 1'b1;
			sTick <= wrap;			// registered, one cycle wide
		end
	end

endmodule

`default_nettype wire

// ==== src/byteFifo.sv ====
////////////////////////////////////////////////////////////
// byte fifo
// first-word-fall-through circular buffer, full and empty
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module byteFifo #(
	parameter int addrLen = uartPkg::fifoAddrLenDef
) (
	input wire logic clk,
	input wire logic reset,
	byteFifoIf.storage q
);

	localparam int depth = 2 ** addrLen;

	uartPkg::byte_t mem [depth];		// storage array

	// one extra bit tells a full wrap from an empty buffer
	logic [addrLen:0] wrPtr;
	logic [addrLen:0] rdPtr;

	logic doWrite;
	logic doRead;

	////////////////////////////////////////////////////////////
	// flags and head

	assign q.empty = (wrPtr == rdPtr);
	assign q.full = (wrPtr[addrLen] != rdPtr[addrLen]) &&
		(wrPtr[addrLen-1:0] == rdPtr[addrLen-1:0]);

	assign q.rdData = mem[rdPtr[addrLen-1:0]];	// fall through, no read latency

	assign doWrite = q.wr && !q.full;		// write while full dropped
	assign doRead = q.rd && !q.empty;		// read while empty ignored

	////////////////////////////////////////////////////////////
	// storage

	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr[addrLen-1:0]] <= q.wrData;
	end

	////////////////////////////////////////////////////////////
	// pointers

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;	// both may move in one cycle
		end
	end

endmodule

`default_nettype wire

// ==== src/uartTrans.sv ====
////////////////////////////////////////////////////////////
// uart transmitter
// pops the tx fifo and sends start, data lsb first, stop
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartTrans #(
	parameter int dataBits = uartPkg::dataBitsDef,
	parameter int sbTick = uartPkg::sbTickDef
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic sTick,
	byteFifoIf.consumer txQ,
	output logic tx
);

	// tick counter covers a bit or the stop period, whichever is longer
	localparam int sMax = (sbTick > uartPkg::overSample) ? sbTick : uartPkg::overSample;
	localparam int sLen = $clog2(sMax);
	localparam int nLen = $clog2(dataBits + 1);

	typedef enum logic [1:0] {idle, start, data, stop} state_t;

	state_t stateReg, stateNext;
	logic [sLen-1:0] sReg, sNext;		// tick counter
	logic [nLen-1:0] nReg, nNext;		// data bit counter
	uartPkg::byte_t bReg, bNext;		// shift register, lsb goes out
	logic txReg, txNext;				// registered line
	logic txDoneTick;					// pops the fifo

	assign txQ.rd = txDoneTick;
	assign tx = txReg;

	////////////////////////////////////////////////////////////
	// state registers

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;		// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	// payload, no reset needed
	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////////////////////////
	// next state logic

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txDoneTick = 1'b0;

		case (stateReg)
			idle:
			begin
				txNext = 1'b1;
				if (!txQ.empty)
				begin
					txDoneTick = 1'b1;		// take head this cycle
					bNext = txQ.rdData;
					sNext = '0;
					stateNext = start;
				end
			end
			start:
			begin
				txNext = 1'b0;				// start bit
				if (sTick)
				begin
					if (sReg == sLen'(uartPkg::overSample - 1))
					begin
						sNext = '0;
						nNext = '0;
						stateNext = data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == sLen'(uartPkg::overSample - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;		// next bit to lsb
						if (nReg == nLen'(dataBits - 1))
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			stop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == sLen'(sbTick - 1))
						stateNext = idle;		// next byte may start at once
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = idle;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/uartRecv.sv ====
////////////////////////////////////////////////////////////
// uart receiver
// mid-bit sampling, start glitch filter, stop bit check
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartRecv #(
	parameter int dataBits = uartPkg::dataBitsDef,
	parameter int sbTick = uartPkg::sbTickDef
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic sTick,
	input wire logic rx,
	byteFifoIf.producer rxQ,
	output logic frameError
);

	localparam int sMax = (sbTick > uartPkg::overSample) ? sbTick : uartPkg::overSample;
	localparam int sLen = $clog2(sMax);
	localparam int nLen = $clog2(dataBits + 1);

	typedef enum logic [1:0] {idle, start, data, stop} state_t;

	state_t stateReg, stateNext;
	logic [sLen-1:0] sReg, sNext;			// tick counter
	logic [nLen-1:0] nReg, nNext;			// data bit counter
	logic [dataBits-1:0] bReg, bNext;		// assembled byte, filled from msb
	logic [1:0] rxSync;						// two-flop synchronizer
	logic rxPrev;							// for falling edge
	logic rxS;
	logic rxDoneTick;						// good frame, write fifo
	logic stopBad;							// stop sample was low
	logic feReg;

	assign rxS = rxSync[1];
	assign rxQ.wr = rxDoneTick;
	assign rxQ.wrData = uartPkg::byte_t'(bReg);
	assign frameError = feReg;

	////////////////////////////////////////////////////////////
	// registers

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg <= '0;
			nReg <= '0;
			rxSync <= 2'b11;		// line idles high
			rxPrev <= 1'b1;
			feReg <= 1'b0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			rxSync <= {rxSync[0], rx};
			rxPrev <= rxS;
			if (stopBad)
				feReg <= 1'b1;		// sticky until reset
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////////////////////////
	// next state logic

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		stopBad = 1'b0;

		case (stateReg)
			idle:
				if (rxPrev && !rxS)		// falling edge only
				begin
					sNext = '0;
					stateNext = start;
				end
			start:
				if (sTick)
				begin
					// half a bit in, check start bit is still low
					if (sReg == sLen'(uartPkg::overSample / 2 - 1))
					begin
						sNext = '0;
						nNext = '0;
						stateNext = rxS ? idle : data;	// high again, glitch
					end
					else
						sNext = sReg + 1'b1;
				end
			data:
				if (sTick)
				begin
					if (sReg == sLen'(uartPkg::overSample - 1))
					begin
						sNext = '0;
						bNext = {rxS, bReg[dataBits-1:1]};	// lsb arrives first
						if (nReg == nLen'(dataBits - 1))
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			stop:
				if (sTick)
				begin
					if (sReg == sLen'(sbTick - 1))
					begin
						stateNext = idle;
						rxDoneTick = rxS;		// byte enters fifo next edge
						stopBad = !rxS;
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = idle;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/uartPort.sv ====
////////////////////////////////////////////////////////////
// serial port top
// tick generator, tx and rx fifos, transmitter, receiver
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartPort #(
	parameter int dataBits = uartPkg::dataBitsDef,
	parameter int sbTick = uartPkg::sbTickDef,
	parameter int clkPerTick = uartPkg::clkPerTickDef,
	parameter int fifoAddrLen = uartPkg::fifoAddrLenDef
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic wr,						// processor write strobe
	input wire uartPkg::byte_t wrData,
	input wire logic rd,						// processor read strobe
	input wire logic rx,						// serial in
	output uartPkg::byte_t rdData,
	output logic txFull,
	output logic txEmpty,
	output logic rxFull,
	output logic rxEmpty,
	output logic frameError,
	output logic tx							// serial out
);

	logic sTick;

	byteFifoIf txQ();		// processor to transmitter
	byteFifoIf rxQ();		// receiver to processor

	////////////////////////////////////////////////////////////
	// processor side

	assign txQ.wr = wr;
	assign txQ.wrData = wrData;
	assign rxQ.rd = rd;
	assign rdData = rxQ.rdData;

	// status levels
	assign txFull = txQ.full;
	assign txEmpty = txQ.empty;
	assign rxFull = rxQ.full;
	assign rxEmpty = rxQ.empty;

	////////////////////////////////////////////////////////////
	// blocks

	baudTickGen #(.clkPerTick(clkPerTick)) tickGen (
		.clk(clk),
		.reset(reset),
		.sTick(sTick)
	);

	byteFifo #(.addrLen(fifoAddrLen)) txFifo (.clk(clk), .reset(reset), .q(txQ));
	byteFifo #(.addrLen(fifoAddrLen)) rxFifo (.clk(clk), .reset(reset), .q(rxQ));

	uartTrans #(.dataBits(dataBits), .sbTick(sbTick)) trans (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.txQ(txQ),
		.tx(tx)
	);

	uartRecv #(.dataBits(dataBits), .sbTick(sbTick)) recv (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rx(rx),
		.rxQ(rxQ),
		.frameError(frameError)
	);

endmodule

`default_nettype wire

// ==== tb/uartPort_tb.sv ====
////////////////////////////////////////////////////////////
// serial port testbench
// file driven loopback, framing and fifo burst checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartPort_tb;

	localparam int clkPerTickTb = 4;
	localparam int bitCycles = uartPkg::overSample * clkPerTickTb;		// 64 clocks per bit
	localparam int frameCycles = (uartPkg::dataBitsDef + 2) * bitCycles;
	localparam int fifoDepth = 2 ** uartPkg::fifoAddrLenDef;
	localparam int maxRec = 64;

	logic clk;
	logic reset;
	logic wr;
	uartPkg::byte_t wrData;
	logic rd;
	logic rx;
	uartPkg::byte_t rdData;
	logic txFull;
	logic txEmpty;
	logic rxFull;
	logic rxEmpty;
	logic frameError;
	logic tx;

	logic useDriver;		// 1 = serial driver owns rx
	logic driverLine;

	// stimulus records
	logic [7:0] cmdArr [maxRec];
	uartPkg::byte_t argArr [maxRec];
	logic [7:0] expArr [maxRec];
	int nRec;

	int valueErrors;
	int otherErrors;
	int wdCycles;
	logic armed;			// watchdog start
	int seed;
	bit loaded;

	assign rx = useDriver ? driverLine : tx;	// loopback mux

	uartPort #(.clkPerTick(clkPerTickTb)) dut (
		.clk(clk),
		.reset(reset),
		.wr(wr),
		.wrData(wrData),
		.rd(rd),
		.rx(rx),
		.rdData(rdData),
		.txFull(txFull),
		.txEmpty(txEmpty),
		.rxFull(rxFull),
		.rxEmpty(rxEmpty),
		.frameError(frameError),
		.tx(tx)
	);

	////////////////////////////////////////////////////////////
	// compare tasks

	task automatic checkByte(input string name, input uartPkg::byte_t got,
		input uartPkg::byte_t expv);
		if (got !== expv)
		begin
			valueErrors++;
			$display("Error at %0t ns: %s is %02h, expected %02h", $time, name, got, expv);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expv);
		if (got !== expv)
		begin
			valueErrors++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, expv);
		end
	endtask

	// all six status levels, sampled mid-cycle
	task automatic checkFlags(input logic [5:0] expv);
		@(negedge clk);
		checkFlag("tx", tx, expv[5]);
		checkFlag("txFull", txFull, expv[4]);
		checkFlag("txEmpty", txEmpty, expv[3]);
		checkFlag("rxFull", rxFull, expv[2]);
		checkFlag("rxEmpty", rxEmpty, expv[1]);
		checkFlag("frameError", frameError, expv[0]);
	endtask

	////////////////////////////////////////////////////////////
	// waits, each bounded

	task automatic waitTxFall(input int limit, output bit seen);
		int n;
		n = 0;
		@(negedge clk);
		while (tx !== 1'b0 && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		seen = (tx === 1'b0);
	endtask

	task automatic waitRxData(input int limit, output bit seen);
		int n;
		n = 0;
		@(negedge clk);
		while (rxEmpty !== 1'b0 && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		seen = (rxEmpty === 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// processor side

	task automatic writeByte(input uartPkg::byte_t b);
		@(posedge clk);
		wr <= 1'b1;
		wrData <= b;
		@(posedge clk);
		wr <= 1'b0;
	endtask

	// head is checked before the pop
	task automatic readByte(input uartPkg::byte_t expv);
		@(negedge clk);
		checkFlag("rxEmpty before read", rxEmpty, 1'b0);
		checkByte("rdData", rdData, expv);
		@(posedge clk);
		rd <= 1'b1;
		@(posedge clk);
		rd <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// serial side

	// mid-bit samples of one frame on tx
	task automatic checkTxFrame(input uartPkg::byte_t b);
		bit seen;
		waitTxFall(2 * bitCycles, seen);
		if (!seen)
		begin
			otherErrors++;
			$display("transmitter never started a frame, at %0t ns", $time);
		end
		else
		begin
			repeat (bitCycles / 2) @(negedge clk);		// middle of start bit
			checkFlag("tx start bit", tx, 1'b0);
			for (int i = 0; i < uartPkg::dataBitsDef; i++)
			begin
				repeat (bitCycles) @(negedge clk);
				checkFlag($sformatf("tx data bit %0d", i), tx, b[i]);	// lsb first
			end
			repeat (bitCycles) @(negedge clk);
			checkFlag("tx stop bit", tx, 1'b1);
		end
	endtask

	// frame with a chosen stop bit, line handed back idle high
	task automatic sendFrame(input uartPkg::byte_t b, input logic stopBit);
		@(posedge clk);
		useDriver <= 1'b1;
		driverLine <= 1'b1;
		repeat (4) @(posedge clk);
		driverLine <= 1'b0;			// start
		repeat (bitCycles) @(posedge clk);
		for (int i = 0; i < uartPkg::dataBitsDef; i++)
		begin
			driverLine <= b[i];
			repeat (bitCycles) @(posedge clk);
		end
		driverLine <= stopBit;
		repeat (bitCycles) @(posedge clk);
		driverLine <= 1'b1;
		repeat (bitCycles) @(posedge clk);
		useDriver <= 1'b0;			// tx idles high too
	endtask

	////////////////////////////////////////////////////////////
	// stimulus file

	task automatic loadRecords(output bit ok);
		int fd;
		int c;
		int n;
		logic [7:0] a;
		logic [7:0] e;
		ok = 1'b0;
		fd = $fopen("tb/uart_stim.txt", "r");
		if (fd != 0)
		begin
			c = $fgetc(fd);
			while (c != -1)
			begin
				if (c[7:0] == "#")
				begin
					while (c != -1 && c != 10)	// skip to end of line
						c = $fgetc(fd);
				end
				else if (c > 32)				// command letter
				begin
					n = $fscanf(fd, " %h %h", a, e);
					if (n == 2 && nRec < maxRec)
					begin
						cmdArr[nRec] = c[7:0];
						argArr[nRec] = a;
						expArr[nRec] = e;
						nRec++;
					end
					else
					begin
						otherErrors++;
						$display("malformed stimulus record after record %0d", nRec);
					end
				end
				if (c != -1)
					c = $fgetc(fd);
			end
			$fclose(fd);
			ok = (nRec > 0);
		end
	endtask

	task automatic runRecords();
		bit seen;
		for (int r = 0; r < nRec; r++)
		begin
			case (cmdArr[r])
				"W":
				begin
					writeByte(argArr[r]);
					checkTxFrame(argArr[r]);
					waitRxData(frameCycles, seen);
					if (!seen)
					begin
						otherErrors++;
						$display("looped back byte never reached the rx fifo, record %0d", r);
					end
					else
						checkByte("rdData echo", rdData, expArr[r]);
				end
				"B":
				begin
					sendFrame(argArr[r], 1'b0);		// low stop bit
					repeat (bitCycles) @(posedge clk);
				end
				"R": readByte(expArr[r]);
				"S": checkFlags(expArr[r][5:0]);
				default:
				begin
					otherErrors++;
					$display("unknown stimulus command in record %0d", r);
				end
			endcase
		end
	endtask

	////////////////////////////////////////////////////////////
	// tx fifo burst

	task automatic runBurst();
		uartPkg::byte_t lead;
		uartPkg::byte_t extra;
		uartPkg::byte_t sent [$];
		bit seen;
		int n;
		lead = uartPkg::byte_t'($urandom());
		extra = uartPkg::byte_t'($urandom());
		for (int i = 0; i < fifoDepth; i++)
			sent.push_back(uartPkg::byte_t'($urandom()));

		// lead byte keeps the transmitter busy while the fifo fills
		writeByte(lead);
		waitTxFall(2 * bitCycles, seen);
		if (!seen)
		begin
			otherErrors++;
			$display("transmitter never took the lead byte of the burst");
		end
		for (int i = 0; i < fifoDepth; i++)
		begin
			@(posedge clk);
			wr <= 1'b1;
			wrData <= sent[i];
		end
		@(posedge clk);
		wrData <= extra;		// fifo full, must be dropped
		@(posedge clk);
		wr <= 1'b0;
		@(negedge clk);
		checkFlag("txFull after burst", txFull, 1'b1);
		checkFlag("txEmpty after burst", txEmpty, 1'b0);

		waitRxData(2 * frameCycles, seen);
		if (!seen)
		begin
			otherErrors++;
			$display("lead byte of the burst never arrived");
		end
		readByte(lead);

		n = 0;
		while (rxFull !== 1'b1 && n < (fifoDepth + 1) * frameCycles)
		begin
			@(negedge clk);
			n++;
		end
		if (rxFull !== 1'b1)
		begin
			otherErrors++;
			$display("rx fifo never filled during the burst");
		end
		foreach (sent[i])
			readByte(sent[i]);			// in write order
		@(negedge clk);
		checkFlag("rxEmpty after burst", rxEmpty, 1'b1);

		// a dropped write must never show up on the line
		repeat (2 * frameCycles) @(negedge clk);
		checkFlag("rxEmpty after idle", rxEmpty, 1'b1);
		checkFlag("txEmpty after idle", txEmpty, 1'b1);
	endtask

	////////////////////////////////////////////////////////////
	// clock, main sequence, watchdog

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;		// 10 ns
	end

	initial
	begin
		reset = 1'b1;
		wr = 1'b0;
		wrData = '0;
		rd = 1'b0;
		useDriver = 1'b0;
		driverLine = 1'b1;
		valueErrors = 0;
		otherErrors = 0;
		nRec = 0;
		armed = 1'b0;
		seed = $urandom(32'ha3b0_0531);
		loadRecords(loaded);
		// two frame times per record and per burst byte, plus slack
		wdCycles = (nRec + fifoDepth + 2) * frameCycles * 2 + 1000;
		armed = 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		if (loaded)
		begin
			runRecords();
			runBurst();
		end
		else
		begin
			otherErrors++;
			$display("stimulus file could not be read or holds no records");
		end

		$display("run complete: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		wait (armed === 1'b1);
		repeat (wdCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, run stopped", wdCycles);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
src/uartPkg.sv
src/byteFifoIf.sv
src/baudTickGen.sv
src/byteFifo.sv
src/uartTrans.sv
src/uartRecv.sv
src/uartPort.sv
tb/uartPort_tb.sv

// ==== Makefile ====
# Verilator build and run of the serial port testbench

BIN = obj_dir/VuartPort_tb
SRCS = src/uartPkg.sv src/byteFifoIf.sv src/baudTickGen.sv src/byteFifo.sv \
	src/uartTrans.sv src/uartRecv.sv src/uartPort.sv tb/uartPort_tb.sv

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) compile.f
	verilator --binary --timing -j 0 --top-module uartPort_tb -Mdir obj_dir -f compile.f

# the stimulus file is read at run time from the project root
run: $(BIN) tb/uart_stim.txt
	$(BIN) > sim.log 2>&1
	cat sim.log
	! grep -q '>>> FAIL' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/uart_stim.txt ====
# columns: command byte expected (W write and echo, B bad stop frame, R read, S flags)
# S expected bits: 5 tx, 4 txFull, 3 txEmpty, 2 rxFull, 1 rxEmpty, 0 frameError
S 00 2a
W a5 a5
S 00 28
R 00 a5
S 00 2a
W 00 00
R 00 00
W ff ff
R 00 ff
W 3c 3c
R 00 3c
B 5a 00
S 00 2b
W 81 81
R 00 81
S 00 2b
B 00 00
S 00 2b
W 7e 7e
R 00 7e
S 00 2b
